/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - src
    files:
      - src/decodePkg.sv
      - src/fetchDecodeReg.sv
      - src/controlDecoder.sv
      - src/regFile.sv
      - src/immGen.sv
      - src/branchUnit.sv
      - src/decodeStage.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/decodeTb.sv

/* all.f */
+incdir+src
src/decodePkg.sv
src/fetchDecodeReg.sv
src/controlDecoder.sv
src/regFile.sv
src/immGen.sv
src/branchUnit.sv
src/decodeStage.sv
tb/decodeTb.sv

/* src/branchUnit.sv */
// early branch resolution, forwarding muxes from memory stage and fetch redirect
`timescale 1ns/1ps
`include "decode_consts.svh"

module branchUnit
  import decodePkg::*;
(
  input  logic [`DATA_W-1:0] dataA,
  input  logic [`DATA_W-1:0] dataB,
  input  logic [`DATA_W-1:0] aluOutM,
  input  logic               forwardA,
  input  logic               forwardB,
  input  logic [1:0]         branch,
  input  logic               jump,
  output branchOpsT          ops,
  output logic               pcSrc,
  output logic               redirect
);

  logic opsEqual;

  // memory stage result overrides a stale regfile read
  assign ops.rd1 = forwardA ? aluOutM : dataA;
  assign ops.rd2 = forwardB ? aluOutM : dataB;

  assign opsEqual = (ops.rd1 == ops.rd2);

  always_comb
  begin
    case (branch)
      BR_BEQ:  pcSrc = opsEqual;
      BR_BNE:  pcSrc = !opsEqual;
      default: pcSrc = 1'b0;
    endcase
  end

  // any taken control transfer kills the slot behind it
  assign redirect = pcSrc | jump;

endmodule

/* src/controlDecoder.sv */
// main control decoder, maps an instruction word to the stage control word
`timescale 1ns/1ps
`include "decode_consts.svh"

module controlDecoder
  import decodePkg::*;
(
  input  logic [`DATA_W-1:0] instr,
  output ctrlWordT           ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // common shape of every ALU op that writes its result back
  function automatic ctrlWordT aluWord(logic [2:0] aluOp, aluSrcT src, logic toRd);
    ctrlWordT c;
    c            = '0;
    c.regWrite   = 1'b1;
    c.wbSrc      = `WB_ALU;
    c.aluControl = aluOp;
    c.aluSrc     = src;
    c.regDst     = toRd;
    return c;
  endfunction

  always_comb
  begin
    ctrl = '0; // nop unless matched below
    if (opcode == `OP_RTYPE)
    begin
      case (funct)
        `FN_NOP:  ctrl = '0;
        `FN_ADD:  ctrl = aluWord(`ALU_ADD, SRC_REG, 1'b1);
        `FN_SUB:  ctrl = aluWord(`ALU_SUB, SRC_REG, 1'b1);
        `FN_AND:  ctrl = aluWord(`ALU_AND, SRC_REG, 1'b1);
        `FN_OR:   ctrl = aluWord(`ALU_OR, SRC_REG, 1'b1);
        `FN_XOR:  ctrl = aluWord(`ALU_XOR, SRC_REG, 1'b1);
        `FN_XNOR: ctrl = aluWord(`ALU_XNOR, SRC_REG, 1'b1);
        `FN_SLT:  ctrl = aluWord(`ALU_SLT, SRC_REG, 1'b1);
        `FN_MULT, `FN_MULTU:
        begin
          ctrl.wbSrc      = `WB_ALU;
          ctrl.multStart  = 1'b1;         // result lands in hi/lo, no reg write
          ctrl.multSigned = (funct == `FN_MULT);
        end
        `FN_MFLO, `FN_MFHI:
        begin
          ctrl.regWrite = 1'b1;
          ctrl.wbSrc    = (funct == `FN_MFLO) ? `WB_LO : `WB_HI;
          ctrl.regDst   = 1'b1;
        end
        default:  ctrl.illegal = 1'b1;
      endcase
    end
    else
    begin
      case (opcode)
        `OP_ADDI: ctrl = aluWord(`ALU_ADD, SRC_SIMM, 1'b0);
        `OP_ANDI: ctrl = aluWord(`ALU_AND, SRC_UIMM, 1'b0);
        `OP_ORI:  ctrl = aluWord(`ALU_OR, SRC_UIMM, 1'b0);
        `OP_XORI: ctrl = aluWord(`ALU_XOR, SRC_UIMM, 1'b0);
        `OP_SLTI: ctrl = aluWord(`ALU_SLT, SRC_SIMM, 1'b0);
        `OP_LUI:  ctrl = aluWord(`ALU_LUI, SRC_SIMM, 1'b0);
        `OP_LW:
        begin
          ctrl       = aluWord(`ALU_ADD, SRC_SIMM, 1'b0);
          ctrl.wbSrc = `WB_MEM;           // load data, not the address
        end
        `OP_SW:
        begin
          ctrl          = aluWord(`ALU_ADD, SRC_SIMM, 1'b0);
          ctrl.regWrite = 1'b0;
          ctrl.memWrite = 1'b1;
        end
        `OP_JAL:
        begin
          ctrl.regWrite = 1'b1;
          ctrl.wbSrc    = `WB_PC;         // link value
          ctrl.jump     = 1'b1;
        end
        `OP_BEQ, `OP_BNE:
        begin
          ctrl.wbSrc      = `WB_ALU;
          ctrl.aluControl = `ALU_SLT;
          ctrl.branch     = (opcode == `OP_BEQ) ? BR_BEQ : BR_BNE;
        end
        default:  ctrl.illegal = 1'b1;
      endcase
    end
  end

endmodule

/* src/decodePkg.sv */
// shared packed types of the decode stage; modules pull them in with a wildcard import
`include "decode_consts.svh"

package decodePkg;

  // second ALU operand source
  typedef enum logic [1:0] {
    SRC_REG  = 2'b00,
    SRC_SIMM = 2'b01, // sign extended immediate
    SRC_UIMM = 2'b10  // zero extended immediate
  } aluSrcT;

  // branch kind resolved in decode
  typedef enum logic [1:0] {
    BR_NONE = 2'b00,
    BR_BEQ  = 2'b01,
    BR_BNE  = 2'b10
  } branchT;

  // payload of the fetch to decode register
  typedef struct packed {
    logic [`DATA_W-1:0] instruction;
    logic [`DATA_W-1:0] pcPlus4;
  } fetchBundleT;

  // control word handed down the pipe
  typedef struct packed {
    logic       regWrite;
    logic [2:0] wbSrc;
    logic       memWrite;
    logic [2:0] aluControl;
    aluSrcT     aluSrc;
    logic       regDst;     // 1 picks rd, 0 picks rt
    branchT     branch;
    logic       jump;
    logic       multStart;
    logic       multSigned;
    logic       illegal;    // encoding not in the supported set
  } ctrlWordT;

  typedef struct packed {
    logic [`RADDR_W-1:0] rs;
    logic [`RADDR_W-1:0] rt;
    logic [`RADDR_W-1:0] rd;
  } regAddrsT;

  // writeback port from the last stage
  typedef struct packed {
    logic                we;
    logic [`RADDR_W-1:0] addr;
    logic [`DATA_W-1:0]  data;
  } wbPortT;

  typedef struct packed {
    logic [`DATA_W-1:0] signImm;
    logic [`DATA_W-1:0] unsignImm;
    logic [`DATA_W-1:0] pcBranch;
    logic [27:0]        jumpDst; // upper pc bits are added in fetch
  } immBundleT;

  // operands after the forwarding muxes
  typedef struct packed {
    logic [`DATA_W-1:0] rd1;
    logic [`DATA_W-1:0] rd2;
  } branchOpsT;

endpackage

/* src/decodeStage.sv */
// decode stage top, joins the pipeline register, decoder, regfile, immediates and branch logic
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeStage
  import decodePkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  fetchBundleT        fetchIn,
  input  logic               stallD,
  input  logic               forwardA,
  input  logic               forwardB,
  input  logic [`DATA_W-1:0] aluOutM,
  input  wbPortT             wbPort,
  output logic [`DATA_W-1:0] pcPlus4D,
  output ctrlWordT           ctrlD,
  output regAddrsT           regsD,
  output immBundleT          immD,
  output branchOpsT          opsD,
  output logic               pcSrcD,
  output logic               redirectD
);

  fetchBundleT        fetchD;    // registered decode bundle
  logic [`DATA_W-1:0] rfDataA;
  logic [`DATA_W-1:0] rfDataB;

  fetchDecodeReg uFetchDecodeReg (
    .clk      (clk),
    .rst      (rst),
    .stallD   (stallD),
    .flushD   (redirectD),        // flush on own redirect
    .fetchIn  (fetchIn),
    .fetchOut (fetchD)
  );

  assign pcPlus4D = fetchD.pcPlus4;
  assign regsD.rs = fetchD.instruction[25:21];
  assign regsD.rt = fetchD.instruction[20:16];
  assign regsD.rd = fetchD.instruction[15:11];

  controlDecoder uControlDecoder (
    .instr (fetchD.instruction),
    .ctrl  (ctrlD)
  );

  regFile uRegFile (
    .clk    (clk),
    .rst    (rst),
    .readA  (regsD.rs),
    .readB  (regsD.rt),
    .wbPort (wbPort),
    .dataA  (rfDataA),
    .dataB  (rfDataB)
  );

  immGen uImmGen (
    .instr   (fetchD.instruction),
    .pcPlus4 (fetchD.pcPlus4),
    .imm     (immD)
  );

  branchUnit uBranchUnit (
    .dataA    (rfDataA),
    .dataB    (rfDataB),
    .aluOutM  (aluOutM),
    .forwardA (forwardA),
    .forwardB (forwardB),
    .branch   (ctrlD.branch),
    .jump     (ctrlD.jump),
    .ops      (opsD),
    .pcSrc    (pcSrcD),
    .redirect (redirectD)
  );

endmodule

/* src/decode_consts.svh */
// ISA constants for the decode stage; include wherever opcodes, codes or widths are needed
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// fixed ISA widths
`define DATA_W     32
`define RADDR_W    5
`define REG_COUNT  32

// primary opcodes, instr[31:26]
`define OP_RTYPE   6'b000000
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDI    6'b001000
`define OP_SLTI    6'b001010
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

// R-type funct codes, instr[5:0]
`define FN_NOP     6'b000000
`define FN_MFHI    6'b010000
`define FN_MFLO    6'b010010
`define FN_MULT    6'b011000
`define FN_MULTU   6'b011001
`define FN_ADD     6'b100000
`define FN_SUB     6'b100010
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_XNOR    6'b100111
`define FN_SLT     6'b101010

// ALU control, as seen by the execute stage
`define ALU_AND    3'b000
`define ALU_OR     3'b001
`define ALU_ADD    3'b010
`define ALU_XOR    3'b011
`define ALU_XNOR   3'b100
`define ALU_SUB    3'b101
`define ALU_SLT    3'b110
`define ALU_LUI    3'b111

// writeback source select
`define WB_PC      3'b000
`define WB_ALU     3'b010
`define WB_MEM     3'b011
`define WB_LO      3'b100
`define WB_HI      3'b110

`endif

/* src/fetchDecodeReg.sv */
// fetch to decode pipeline register, holds on stall and clears on a taken redirect
`timescale 1ns/1ps

module fetchDecodeReg
  import decodePkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        stallD,
  input  logic        flushD,
  input  fetchBundleT fetchIn,
  output fetchBundleT fetchOut
);

  // all-zero instruction decodes as nop, so clearing is enough to kill it
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      fetchOut <= '0;
    end
    else if (flushD)
    begin
      fetchOut <= '0;             // branch taken or jump, drop the fetched slot
    end
    else if (!stallD)
    begin
      fetchOut <= fetchIn;
    end
    // stalled, keep current contents
  end

endmodule

/* src/immGen.sv */
// immediate extension plus branch and jump target arithmetic for the decode stage
`timescale 1ns/1ps
`include "decode_consts.svh"

module immGen
  import decodePkg::*;
(
  input  logic [`DATA_W-1:0] instr,
  input  logic [`DATA_W-1:0] pcPlus4,
  output immBundleT          imm
);

  logic [`DATA_W-1:0] signExt;

  assign signExt = {{16{instr[15]}}, instr[15:0]};

  always_comb
  begin
    imm.signImm   = signExt;
    imm.unsignImm = {16'b0, instr[15:0]};          // for andi, ori, xori
    imm.pcBranch  = pcPlus4 + {signExt[29:0], 2'b00}; // word offset from pc+4
    imm.jumpDst   = {instr[25:0], 2'b00};
  end

endmodule

/* src/regFile.sv */
// 32-entry register file with two async reads, write-through bypass and one write port
`timescale 1ns/1ps
`include "decode_consts.svh"

module regFile
  import decodePkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [`RADDR_W-1:0] readA,
  input  logic [`RADDR_W-1:0] readB,
  input  wbPortT              wbPort,
  output logic [`DATA_W-1:0]  dataA,
  output logic [`DATA_W-1:0]  dataB
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wbPort.we && (wbPort.addr != '0))
    begin
      regs[wbPort.addr] <= wbPort.data; // r0 stays zero
    end
  end

  // r0 reads zero and a pending write to the same reg wins over the array
  always_comb
  begin
    if (readA == '0)
      dataA = '0;
    else if (wbPort.we && (wbPort.addr == readA))
      dataA = wbPort.data;
    else
      dataA = regs[readA];
  end

  always_comb
  begin
    if (readB == '0)
      dataB = '0;
    else if (wbPort.we && (wbPort.addr == readB))
      dataB = wbPort.data;
    else
      dataB = regs[readB];
  end

endmodule

/* tb/decodeTb.sv */
// testbench for decodeStage that replays tb/decode_tests.txt one cycle per vector and checks outputs
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeTb
  import decodePkg::*;
();

  // one parsed line of the vector file
  typedef struct packed {
    logic               stall;
    logic               fwdA;
    logic               fwdB;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] aluM;
    logic               we;
    logic [4:0]         addr;
    logic [`DATA_W-1:0] wdata;
    ctrlWordT           ctrl;
    regAddrsT           regs;
    logic [`DATA_W-1:0] signImm;
    logic [`DATA_W-1:0] unsignImm;
    logic [`DATA_W-1:0] pcBranch;
    logic [27:0]        jumpDst;
    logic [`DATA_W-1:0] rd1;
    logic [`DATA_W-1:0] rd2;
    logic               pcSrc;
    logic               redirect;
  } vectorT;

  logic               clk = 1'b0;
  logic               rst = 1'b1;
  fetchBundleT        fetchIn;
  logic               stallD;
  logic               forwardA;
  logic               forwardB;
  logic [`DATA_W-1:0] aluOutM;
  wbPortT             wbPort;
  logic [`DATA_W-1:0] pcPlus4D;
  ctrlWordT           ctrlD;
  regAddrsT           regsD;
  immBundleT          immD;
  branchOpsT          opsD;
  logic               pcSrcD;
  logic               redirectD;

  vectorT vectors[$];
  int     errors = 0;

  decodeStage DUT (
    .clk       (clk),
    .rst       (rst),
    .fetchIn   (fetchIn),
    .stallD    (stallD),
    .forwardA  (forwardA),
    .forwardB  (forwardB),
    .aluOutM   (aluOutM),
    .wbPort    (wbPort),
    .pcPlus4D  (pcPlus4D),
    .ctrlD     (ctrlD),
    .regsD     (regsD),
    .immD      (immD),
    .opsD      (opsD),
    .pcSrcD    (pcSrcD),
    .redirectD (redirectD)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  // reset held for 4 rising edges and released just after the last
  initial
  begin
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
  end

  // hard stop in case the run stalls somewhere
  initial
  begin
    #100000;
    $display("simulation ran past its time limit");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual,
                                int index);
    $display("Fail %s: expected %h, got %h (vector %0d)", name, expected, actual, index);
    errors++;
  endtask

  task automatic loadVectors();
    int          fd;
    int          got;
    int          lineNo;
    string       line;
    logic [31:0] f [19];
    vectorT      v;
    lineNo = 0;
    fd = $fopen("tb/decode_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tb/decode_tests.txt");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      got = $fgets(line, fd);
      lineNo++;
      if (got == 0 || line.len() < 2 || line[0] == "#")
        continue; // blank or comment
      got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
      if (got != 19)
      begin
        $display("line %0d of the vector file has %0d fields instead of 19", lineNo, got);
        errors++;
        continue;
      end
      v = {f[0][0], f[1][0], f[2][0], f[3], f[4], f[5], f[6][0], f[7][4:0], f[8],
           f[9][16:0], f[10][14:0], f[11], f[12], f[13], f[14][27:0], f[15], f[16],
           f[17][0], f[18][0]};
      vectors.push_back(v);
    end
    $fclose(fd);
    if (vectors.size() == 0)
    begin
      $display("the vector file holds no vectors");
      errors++;
    end
  endtask

  task automatic applyInputs(vectorT v);
    stallD              = v.stall;
    forwardA            = v.fwdA;
    forwardB            = v.fwdB;
    fetchIn.instruction = v.instr;
    fetchIn.pcPlus4     = v.pc;
    aluOutM             = v.aluM;
    wbPort.we           = v.we;
    wbPort.addr         = v.addr;
    wbPort.data         = v.wdata;
  endtask

  task automatic checkOutputs(vectorT v, logic [`DATA_W-1:0] expPc, int index);
    if (pcPlus4D !== expPc)
      reportMismatch("pcPlus4D", expPc, pcPlus4D, index);
    if (ctrlD !== v.ctrl)
      reportMismatch("ctrlD", v.ctrl, ctrlD, index);
    if (regsD !== v.regs)
      reportMismatch("regsD", v.regs, regsD, index);
    if (immD.signImm !== v.signImm)
      reportMismatch("immD.signImm", v.signImm, immD.signImm, index);
    if (immD.unsignImm !== v.unsignImm)
      reportMismatch("immD.unsignImm", v.unsignImm, immD.unsignImm, index);
    if (immD.pcBranch !== v.pcBranch)
      reportMismatch("immD.pcBranch", v.pcBranch, immD.pcBranch, index);
    if (immD.jumpDst !== v.jumpDst)
      reportMismatch("immD.jumpDst", v.jumpDst, immD.jumpDst, index);
    if (opsD.rd1 !== v.rd1)
      reportMismatch("opsD.rd1", v.rd1, opsD.rd1, index);
    if (opsD.rd2 !== v.rd2)
      reportMismatch("opsD.rd2", v.rd2, opsD.rd2, index);
    if (pcSrcD !== v.pcSrc)
      reportMismatch("pcSrcD", v.pcSrc, pcSrcD, index);
    if (redirectD !== v.redirect)
      reportMismatch("redirectD", v.redirect, redirectD, index);
  endtask

  initial
  begin
    int                 waitCycles;
    logic [`DATA_W-1:0] expPc;
    fetchIn  = '0;
    stallD   = 1'b0;
    forwardA = 1'b0;
    forwardB = 1'b0;
    aluOutM  = '0;
    wbPort   = '0;
    loadVectors();

    waitCycles = 0;
    while (rst && waitCycles < 20)
    begin
      @(posedge clk);
      waitCycles++;
    end

    if (rst)
    begin
      $display("reset was still asserted after %0d cycles", waitCycles);
      errors++;
    end
    else
    begin
      expPc = '0; // bundle after reset holds the idle zero fetch
      for (int i = 0; i < vectors.size(); i++)
      begin
        // model of the pipeline register pc, flush beats stall
        if (i > 0)
        begin
          if (vectors[i-1].redirect)
            expPc = '0;
          else if (!vectors[i-1].stall)
            expPc = vectors[i-1].pc;
        end
        @(posedge clk);
        #1 applyInputs(vectors[i]);
        #8 checkOutputs(vectors[i], expPc, i); // just before the next edge
      end
    end

    $display("checked %0d vectors, %0d errors", vectors.size(), errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb/decode_tests.txt */
# in: stall fwdA fwdB instr pcPlus4 aluOutM wbWe wbAddr wbData (hex)
# exp: ctrl regs signImm unsignImm pcBranch jumpDst rd1 rd2 pcSrc redirect (hex)
# expected columns are the outputs in the same cycle; they decode the previous line's instr
# after reset, fetch addi r1,r0,0x1234 and write r2
0 0 0 20011234 104 0 1 2 AAAA5555  0 0 0 0 0 0 0 0 0 0
0 0 0 34038001 108 0 1 3 12345678  14480 22 1234 1234 49D4 448D0 0 0 0 0
# ori with negative looking imm, write to r0 ignored
0 0 0 00432020 10C 0 1 0 DEADBEEF  14300 70 FFFF8001 8001 FFFE010C E0004 0 12345678 0 0
# add r4,r2,r3 reads r2 through the bypass
0 0 0 00002822 110 0 1 2 55550000  14440 864 2020 2020 818C 10C8080 55550000 12345678 0 0
0 0 0 1002FFFE 114 0 0 0 0  14A40 5 2822 2822 A198 A088 0 0 0 0
# beq r0,r2 not taken, r0 still zero
0 0 0 14430010 118 0 0 0 0  4C10 5F FFFFFFFE FFFE 10C BFFF8 0 55550000 0 0
# bne r2,r3 taken, next fetch is flushed
0 0 0 00432020 11C 0 0 0 0  4C20 860 10 10 158 10C0040 55550000 12345678 1 1
0 0 0 10430004 120 0 0 0 0  0 0 0 0 0 0 0 0 0 0
# beq r2,r3 taken with both operands forwarded
0 1 1 0C100040 124 77777777 0 0 0  4C10 860 4 4 130 10C0010 77777777 77777777 1 1
0 0 0 0C100040 128 0 0 0 0  0 0 0 0 0 0 0 0 0 0
# jal redirects
0 0 0 8C460008 12C 0 0 0 0  10008 200 40 40 228 400100 0 0 0 1
0 0 0 8C460008 130 0 0 0 0  0 0 0 0 0 0 0 0 0 0
# lw held under stall, r6 written during the stall
1 0 0 AC470004 134 0 0 0 0  16480 8C0 8 8 150 1180020 55550000 0 0 0
1 0 0 AC470004 134 0 1 6 66666666  16480 8C0 8 8 150 1180020 55550000 66666666 0 0
0 0 0 AC470004 134 0 0 0 0  16480 8C0 8 8 150 1180020 55550000 66666666 0 0
# sw, then illegal opcode
0 0 0 FC000000 138 0 0 0 0  5480 8E0 4 4 144 11C0010 55550000 0 0 0
0 0 0 00430018 13C 0 0 0 0  1 0 0 0 138 0 0 0 0 0
# mult, mflo, lui
0 0 0 00004012 140 0 0 0 0  4006 860 18 18 19C 10C0060 55550000 12345678 0 0
0 0 0 3C09ABCD 144 0 0 0 0  18040 8 4012 4012 10188 10048 0 0 0 0
0 0 0 00000000 148 0 0 0 0  14E80 135 FFFFABCD ABCD FFFEB078 26AF34 0 0 0 0
0 0 0 00000000 0 0 0 0 0  0 0 0 0 148 0 0 0 0 0
